// File: common/creator_pkg.sv
// Shared widths, address map, register bus types and FSM encodings, imported by every RTL file
package creator_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  // Word address and data width of the register bus
  localparam int ADDR_WIDTH = 15;
  localparam int DATA_WIDTH = 16;

  // Top address bits pick the slave
  localparam int SEL_WIDTH  = 3;
  // Remaining low bits address words inside a slave
  localparam int OFFS_WIDTH = ADDR_WIDTH - SEL_WIDTH;

  // Slave select codes, 0x0000 and 0x4000 in the word map
  localparam logic [SEL_WIDTH-1:0] CONFIG_BASE = 3'b000;
  localparam logic [SEL_WIDTH-1:0] GPIO_BASE   = 3'b100;

  // SPI frame layout, command half then data half
  localparam int FRAME_BITS = 32;
  localparam int CMD_BITS   = 16;

  // --------------------------------------------------
  // Bus structs
  // --------------------------------------------------
  // Request from the master, held steady until ack
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat;
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } bus_req_t;

  // Response from a slave, dat valid with ack
  typedef struct packed {
    logic [DATA_WIDTH-1:0] dat;
    logic                  ack;
  } bus_rsp_t;

  // Decoder slave choice
  typedef enum logic [1:0] {SEL_CONFIG, SEL_GPIO, SEL_NONE} slave_sel_e;

  // SPI bridge states
  typedef enum logic [1:0] {SPI_IDLE, SPI_CMD, SPI_BUS, SPI_DATA} spi_state_e;

  // --------------------------------------------------
  // Word offsets inside each slave
  // --------------------------------------------------
  // Version word 0 is least significant
  localparam logic [OFFS_WIDTH-1:0] CFG_VERSION0    = 'd0;
  localparam logic [OFFS_WIDTH-1:0] CFG_VERSION1    = 'd1;
  localparam logic [OFFS_WIDTH-1:0] CFG_VERSION2    = 'd2;
  localparam logic [OFFS_WIDTH-1:0] CFG_VERSION3    = 'd3;
  localparam logic [OFFS_WIDTH-1:0] CFG_SAMPLE_RATE = 'd4;
  localparam logic [OFFS_WIDTH-1:0] CFG_DATA_GAIN   = 'd5;

  // GPIO register words
  localparam logic [OFFS_WIDTH-1:0] GPIO_DIR = 'd0;
  localparam logic [OFFS_WIDTH-1:0] GPIO_OUT = 'd1;
  localparam logic [OFFS_WIDTH-1:0] GPIO_IN  = 'd2;

endpackage

// File: spi/spi_bus_master.sv
// SPI slave bridge, turns host frames into single-word register bus reads and writes
`timescale 1ns/1ps

module spi_bus_master import creator_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  // Host SPI pins, mode 0
  input  logic     sck_i,
  input  logic     ss_n_i,
  input  logic     mosi_i,
  output logic     miso_o,
  // Register bus master side
  output bus_req_t bus_req_o,
  input  bus_rsp_t bus_rsp_i
);

  localparam int CNT_WIDTH = $clog2(FRAME_BITS);
  // Counter values on the last bit of each half
  localparam logic [CNT_WIDTH-1:0] CMD_LAST   = CNT_WIDTH'(CMD_BITS - 1);
  localparam logic [CNT_WIDTH-1:0] FRAME_LAST = CNT_WIDTH'(FRAME_BITS - 1);

  // --------------------------------------------------
  // Pin synchronizers and edge detect
  // --------------------------------------------------
  // Bits 1:0 synchronize, bit 2 is the previous value
  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] mosi_q;

  logic sck_rise;
  logic sck_fall;
  logic ss_fall;
  logic ss_high;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_fall  = ~ss_q[1] & ss_q[2];
  // Select released, aborts a frame in progress
  assign ss_high  = ss_q[1];

  // --------------------------------------------------
  // Frame FSM
  // --------------------------------------------------
  spi_state_e            state_q;
  logic [CNT_WIDTH-1:0]  bit_cnt_q;
  // Receive shifter, command then write data
  logic [DATA_WIDTH-1:0] rx_q;
  logic [DATA_WIDTH-1:0] rx_next;
  // Transmit shifter for read data
  logic [DATA_WIDTH-1:0] tx_q;
  logic                  miso_q;
  bus_req_t              req_q;

  // MSB first, new bit enters at the bottom
  assign rx_next = {rx_q[DATA_WIDTH-2:0], mosi_q[1]};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_q     <= 3'b000;
      ss_q      <= 3'b111;
      mosi_q    <= 2'b00;
      state_q   <= SPI_IDLE;
      bit_cnt_q <= '0;
      rx_q      <= '0;
      tx_q      <= '0;
      miso_q    <= 1'b0;
      req_q     <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck_i};
      ss_q   <= {ss_q[1:0], ss_n_i};
      mosi_q <= {mosi_q[0], mosi_i};
      case (state_q)
        SPI_IDLE: begin
          // Wait for a fresh select edge
          if (ss_fall) begin
            state_q   <= SPI_CMD;
            bit_cnt_q <= '0;
            miso_q    <= 1'b0;
          end
        end
        SPI_CMD: begin
          if (ss_high) begin
            state_q <= SPI_IDLE;
          end else if (sck_rise) begin
            rx_q      <= rx_next;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == CMD_LAST) begin
              // Bit 15 is the write flag, 14:0 the word address
              req_q.we  <= rx_next[CMD_BITS-1];
              req_q.adr <= rx_next[ADDR_WIDTH-1:0];
              if (rx_next[CMD_BITS-1]) begin
                state_q <= SPI_DATA;
              end else begin
                // Read goes out right after the command half
                req_q.cyc <= 1'b1;
                req_q.stb <= 1'b1;
                state_q   <= SPI_BUS;
              end
            end
          end
        end
        SPI_BUS: begin
          // Hold the request until ack, even if select drops
          if (bus_rsp_i.ack) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            if (req_q.we) begin
              state_q <= SPI_IDLE;
            end else begin
              tx_q    <= bus_rsp_i.dat;
              state_q <= SPI_DATA;
            end
          end
        end
        SPI_DATA: begin
          if (ss_high) begin
            // Early release, no write is issued
            state_q <= SPI_IDLE;
          end else begin
            if (sck_rise) begin
              rx_q      <= rx_next;
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == FRAME_LAST) begin
                if (req_q.we) begin
                  req_q.dat <= rx_next;
                  req_q.cyc <= 1'b1;
                  req_q.stb <= 1'b1;
                  state_q   <= SPI_BUS;
                end else begin
                  state_q <= SPI_IDLE;
                end
              end
            end
            // Read data changes on falling edges
            if (sck_fall && !req_q.we) begin
              miso_q <= tx_q[DATA_WIDTH-1];
              tx_q   <= {tx_q[DATA_WIDTH-2:0], 1'b0};
            end
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  assign bus_req_o = req_q;
  assign miso_o    = miso_q;

  // Pending request stays put until the slave acks it
  a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    bus_req_o.stb && !bus_rsp_i.ack |=> bus_req_o.stb && $stable(bus_req_o));

endmodule

// File: src/bus_decoder.sv
// Single-master bus interconnect that routes by top address bits and acks unmapped space
`timescale 1ns/1ps

module bus_decoder import creator_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  // Master port
  input  bus_req_t m_req_i,
  output bus_rsp_t m_rsp_o,
  // Configuration bank port
  output bus_req_t cfg_req_o,
  input  bus_rsp_t cfg_rsp_i,
  // GPIO port
  output bus_req_t gpio_req_o,
  input  bus_rsp_t gpio_rsp_i
);

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  logic [SEL_WIDTH-1:0] sel_bits;
  slave_sel_e           sel;

  assign sel_bits = m_req_i.adr[ADDR_WIDTH-1 -: SEL_WIDTH];

  always_comb begin
    case (sel_bits)
      CONFIG_BASE: sel = SEL_CONFIG;
      GPIO_BASE:   sel = SEL_GPIO;
      default:     sel = SEL_NONE;
    endcase
  end

  // Strobes reach only the chosen slave
  always_comb begin
    cfg_req_o      = m_req_i;
    gpio_req_o     = m_req_i;
    cfg_req_o.cyc  = m_req_i.cyc & (sel == SEL_CONFIG);
    cfg_req_o.stb  = m_req_i.stb & (sel == SEL_CONFIG);
    gpio_req_o.cyc = m_req_i.cyc & (sel == SEL_GPIO);
    gpio_req_o.stb = m_req_i.stb & (sel == SEL_GPIO);
  end

  // --------------------------------------------------
  // Unmapped space
  // --------------------------------------------------
  // One-cycle ack so the master never hangs
  logic none_ack_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= m_req_i.cyc & m_req_i.stb & (sel == SEL_NONE) & ~none_ack_q;
    end
  end

  // Response mux back to the master
  always_comb begin
    case (sel)
      SEL_CONFIG: m_rsp_o = cfg_rsp_i;
      SEL_GPIO:   m_rsp_o = gpio_rsp_i;
      default:    m_rsp_o = '{dat: '0, ack: none_ack_q};
    endcase
  end

  // At most one responder at a time
  a_one_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0({cfg_rsp_i.ack, gpio_rsp_i.ack, none_ack_q}));
  // An ack only comes from the addressed slave
  a_ack_sel: assert property (@(posedge clk) disable iff (!arst_n_i)
    (!cfg_rsp_i.ack || sel == SEL_CONFIG) && (!gpio_rsp_i.ack || sel == SEL_GPIO));

endmodule

// File: src/config_regs.sv
// Configuration register bank on the bus, version words plus mic sample-rate and gain settings
`timescale 1ns/1ps

module config_regs import creator_pkg::*; #(
  parameter logic [63:0]           VERSION             = 64'h0,
  parameter logic [DATA_WIDTH-1:0] SAMPLE_RATE_DEFAULT = 16'd8,
  parameter logic [DATA_WIDTH-1:0] DATA_GAIN_DEFAULT   = 16'd3
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Bus slave port
  input  bus_req_t              bus_req_i,
  output bus_rsp_t              bus_rsp_o,
  // Microphone settings
  output logic [DATA_WIDTH-1:0] sample_rate_o,
  output logic [DATA_WIDTH-1:0] data_gain_o
);

  logic [OFFS_WIDTH-1:0] offs;
  logic                  access;
  logic                  ack_q;
  logic [DATA_WIDTH-1:0] rdat_q;
  logic [DATA_WIDTH-1:0] rate_q;
  logic [DATA_WIDTH-1:0] gain_q;

  assign offs = bus_req_i.adr[OFFS_WIDTH-1:0];
  // New access, blocked in the ack cycle so ack lasts one clock
  assign access = bus_req_i.cyc & bus_req_i.stb & ~ack_q;

  // --------------------------------------------------
  // Writable registers and ack
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q  <= 1'b0;
      rate_q <= SAMPLE_RATE_DEFAULT;
      gain_q <= DATA_GAIN_DEFAULT;
    end else begin
      ack_q <= access;
      if (access && bus_req_i.we) begin
        // Version words are read only
        case (offs)
          CFG_SAMPLE_RATE: rate_q <= bus_req_i.dat;
          CFG_DATA_GAIN:   gain_q <= bus_req_i.dat;
          default:         ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Read data, valid together with ack
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (access) begin
      case (offs)
        CFG_VERSION0:    rdat_q <= VERSION[0*DATA_WIDTH +: DATA_WIDTH];
        CFG_VERSION1:    rdat_q <= VERSION[1*DATA_WIDTH +: DATA_WIDTH];
        CFG_VERSION2:    rdat_q <= VERSION[2*DATA_WIDTH +: DATA_WIDTH];
        CFG_VERSION3:    rdat_q <= VERSION[3*DATA_WIDTH +: DATA_WIDTH];
        CFG_SAMPLE_RATE: rdat_q <= rate_q;
        CFG_DATA_GAIN:   rdat_q <= gain_q;
        // Unused words read as zero
        default:         rdat_q <= '0;
      endcase
    end
  end

  assign bus_rsp_o.dat = rdat_q;
  assign bus_rsp_o.ack = ack_q;
  assign sample_rate_o = rate_q;
  assign data_gain_o   = gain_q;

  // Ack only ever answers a strobe from the cycle before
  a_ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
    bus_rsp_o.ack |-> $past(bus_req_i.stb));

endmodule

// File: src/gpio_port.sv
// GPIO peripheral on the bus, direction and output registers plus synchronized pin inputs
`timescale 1ns/1ps

module gpio_port import creator_pkg::*; #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Bus slave port
  input  bus_req_t              bus_req_i,
  output bus_rsp_t              bus_rsp_o,
  // Split pin interface
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  logic [OFFS_WIDTH-1:0] offs;
  logic                  access;
  logic                  ack_q;
  logic [DATA_WIDTH-1:0] rdat_q;
  // Direction, 1 drives the pin
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  // Two-flop input sync
  logic [GPIO_WIDTH-1:0] in_meta_q;
  logic [GPIO_WIDTH-1:0] in_q;

  assign offs   = bus_req_i.adr[OFFS_WIDTH-1:0];
  assign access = bus_req_i.cyc & bus_req_i.stb & ~ack_q;

  // --------------------------------------------------
  // Control registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      dir_q <= '0;
      out_q <= '0;
    end else begin
      ack_q <= access;
      if (access && bus_req_i.we) begin
        // GPIO_IN is read only
        case (offs)
          GPIO_DIR: dir_q <= bus_req_i.dat[GPIO_WIDTH-1:0];
          GPIO_OUT: out_q <= bus_req_i.dat[GPIO_WIDTH-1:0];
          default:  ;
        endcase
      end
    end
  end

  // Pin sync and read mux, zero extended
  always_ff @(posedge clk) begin
    in_meta_q <= gpio_i;
    in_q      <= in_meta_q;
    if (access) begin
      case (offs)
        GPIO_DIR: rdat_q <= DATA_WIDTH'(dir_q);
        GPIO_OUT: rdat_q <= DATA_WIDTH'(out_q);
        GPIO_IN:  rdat_q <= DATA_WIDTH'(in_q);
        default:  rdat_q <= '0;
      endcase
    end
  end

  assign bus_rsp_o.dat = rdat_q;
  assign bus_rsp_o.ack = ack_q;
  assign gpio_o        = out_q;
  assign gpio_oe_o     = dir_q;

endmodule

// File: src/system.sv
// Top level, host SPI bridge, bus interconnect, config bank, GPIO and NFC SPI pass-through
`timescale 1ns/1ps

module system import creator_pkg::*; #(
  parameter logic [63:0]           VERSION             = 64'h44E8_05C3_000A_0001,
  parameter logic [DATA_WIDTH-1:0] SAMPLE_RATE_DEFAULT = 16'd8,
  parameter logic [DATA_WIDTH-1:0] DATA_GAIN_DEFAULT   = 16'd3,
  parameter int                    GPIO_WIDTH          = 16
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Host SPI, shared by both slaves
  input  logic                  sck_i,
  input  logic                  mosi_i,
  input  logic                  ss_n_i,
  input  logic                  ss1_n_i,
  output logic                  miso_o,
  // NFC device SPI
  input  logic                  nfc_miso_i,
  output logic                  nfc_cs_o,
  output logic                  nfc_sck_o,
  output logic                  nfc_mosi_o,
  // Microphone settings
  output logic [DATA_WIDTH-1:0] mic_sample_rate_o,
  output logic [DATA_WIDTH-1:0] mic_data_gain_o,
  // GPIO pins
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  // --------------------------------------------------
  // SPI slave select and NFC pass-through
  // --------------------------------------------------
  logic bridge_miso;

  // Bridge wins, then NFC, idle line high
  assign miso_o     = !ss_n_i ? bridge_miso : (!ss1_n_i ? nfc_miso_i : 1'b1);
  assign nfc_cs_o   = ss1_n_i;
  assign nfc_sck_o  = sck_i;
  assign nfc_mosi_o = mosi_i;

  // --------------------------------------------------
  // Register bus
  // --------------------------------------------------
  bus_req_t m_req, cfg_req, gpio_req;
  bus_rsp_t m_rsp, cfg_rsp, gpio_rsp;

  spi_bus_master u_spi (
    .clk(clk), .arst_n_i(arst_n_i),
    .sck_i(sck_i), .ss_n_i(ss_n_i), .mosi_i(mosi_i), .miso_o(bridge_miso),
    .bus_req_o(m_req), .bus_rsp_i(m_rsp)
  );

  bus_decoder u_dec (
    .clk(clk), .arst_n_i(arst_n_i),
    .m_req_i(m_req), .m_rsp_o(m_rsp),
    .cfg_req_o(cfg_req), .cfg_rsp_i(cfg_rsp),
    .gpio_req_o(gpio_req), .gpio_rsp_i(gpio_rsp)
  );

  config_regs #(
    .VERSION(VERSION),
    .SAMPLE_RATE_DEFAULT(SAMPLE_RATE_DEFAULT),
    .DATA_GAIN_DEFAULT(DATA_GAIN_DEFAULT)
  ) u_cfg (
    .clk(clk), .arst_n_i(arst_n_i),
    .bus_req_i(cfg_req), .bus_rsp_o(cfg_rsp),
    .sample_rate_o(mic_sample_rate_o), .data_gain_o(mic_data_gain_o)
  );

  gpio_port #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
    .clk(clk), .arst_n_i(arst_n_i),
    .bus_req_i(gpio_req), .bus_rsp_o(gpio_rsp),
    .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o)
  );

endmodule

// File: test/tb_system.sv
// Testbench for the system top level, replays host SPI frames from the vector file and checks them
`timescale 1ns/1ps

module tb_system import creator_pkg::*; ();

  localparam logic [63:0] VERSION      = 64'h44E8_05C3_000A_0001;
  localparam logic [15:0] RATE_DEFAULT = 16'd8;
  localparam logic [15:0] GAIN_DEFAULT = 16'd3;
  localparam int          GPIO_WIDTH   = 16;
  // sck half period in clk cycles
  localparam int          HALF_SCK     = 8;
  localparam int          ABORT_BITS   = 20;
  localparam logic [15:0] LFSR_SEED    = 16'd29302;
  localparam string       VECTOR_FILE  = "test/system_vectors.txt";

  logic                  clk;
  logic                  arst_n;
  logic                  sck;
  logic                  mosi;
  logic                  ss_n;
  logic                  ss1_n;
  logic                  nfc_miso;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic                  miso;
  logic                  nfc_cs;
  logic                  nfc_sck;
  logic                  nfc_mosi;
  logic [15:0]           mic_rate;
  logic [15:0]           mic_gain;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oe;

  system #(
    .VERSION(VERSION),
    .SAMPLE_RATE_DEFAULT(RATE_DEFAULT),
    .DATA_GAIN_DEFAULT(GAIN_DEFAULT),
    .GPIO_WIDTH(GPIO_WIDTH)
  ) uut (
    .clk(clk), .arst_n_i(arst_n),
    .sck_i(sck), .mosi_i(mosi), .ss_n_i(ss_n), .ss1_n_i(ss1_n), .miso_o(miso),
    .nfc_miso_i(nfc_miso), .nfc_cs_o(nfc_cs), .nfc_sck_o(nfc_sck), .nfc_mosi_o(nfc_mosi),
    .mic_sample_rate_o(mic_rate), .mic_data_gain_o(mic_gain),
    .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe)
  );

  // Expected register state
  logic [15:0] exp_rate;
  logic [15:0] exp_gain;
  logic [15:0] exp_dir;
  logic [15:0] exp_out;
  int          mismatches   = 0;
  int          other_errors = 0;
  logic        loaded       = 1'b0;
  logic [15:0] lfsr_q;
  // Parsed vector lines
  string       ops[$];
  string       names[$];
  logic [15:0] addrs[$];
  logic [15:0] datas[$];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Lands 10 ns after the n-th rising edge
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_random_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // Register map rules, version and GPIO_IN are read only
  task automatic update_model(input logic [15:0] addr, input logic [15:0] data);
    logic [SEL_WIDTH-1:0]  sel;
    logic [OFFS_WIDTH-1:0] offs;
    sel  = addr[ADDR_WIDTH-1 -: SEL_WIDTH];
    offs = addr[OFFS_WIDTH-1:0];
    if (sel == CONFIG_BASE && offs == CFG_SAMPLE_RATE) exp_rate = data;
    if (sel == CONFIG_BASE && offs == CFG_DATA_GAIN)   exp_gain = data;
    if (sel == GPIO_BASE && offs == GPIO_DIR)          exp_dir  = data;
    if (sel == GPIO_BASE && offs == GPIO_OUT)          exp_out  = data;
  endtask

  task automatic check_ports(input string name);
    check_value({name, " sample_rate"}, exp_rate, mic_rate);
    check_value({name, " data_gain"}, exp_gain, mic_gain);
    check_value({name, " gpio_oe"}, exp_dir, gpio_oe);
    check_value({name, " gpio_out"}, exp_out, gpio_out);
  endtask

  // --------------------------------------------------
  // SPI frame driver, mode 0, MSB first
  // --------------------------------------------------
  task automatic spi_frame(input logic [15:0] cmd, input logic [15:0] wdat, input int nbits,
                           output logic [15:0] rdat);
    logic [FRAME_BITS-1:0] shift;
    shift = {cmd, wdat};
    rdat  = '0;
    ss_n  = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      mosi  = shift[FRAME_BITS-1];
      shift = shift << 1;
      wait_clocks(HALF_SCK);
      // Read data sampled just before the rising edge
      if (i >= CMD_BITS) begin
        rdat = {rdat[14:0], miso};
      end
      sck = 1'b1;
      wait_clocks(HALF_SCK);
      sck = 1'b0;
    end
    // Short frames end here too, which aborts them
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_clocks(4);
  endtask

  // Bridge deselected, NFC selected with random pin data
  task automatic nfc_passthrough(input string name, input int nbits);
    logic miso_bit;
    logic mosi_bit;
    ss1_n = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      take_random_bit(miso_bit);
      take_random_bit(mosi_bit);
      nfc_miso = miso_bit;
      mosi     = mosi_bit;
      sck      = ~sck;
      @(negedge clk);
      check_value({name, " miso"}, 16'(miso_bit), 16'(miso));
      check_value({name, " nfc pins"}, 16'({1'b0, sck, mosi_bit}),
                  16'({nfc_cs, nfc_sck, nfc_mosi}));
      wait_clocks(1);
    end
    ss1_n = 1'b1;
    sck   = 1'b0;
    mosi  = 1'b0;
    @(negedge clk);
    // Nobody selected, line idles high
    check_value({name, " idle miso"}, 16'h0001, 16'(miso));
    check_value({name, " idle nfc_cs"}, 16'h0001, 16'(nfc_cs));
    wait_clocks(1);
  endtask

  task automatic run_vector(input string op, input logic [15:0] addr, input logic [15:0] data,
                            input string name);
    logic [15:0] rd;
    if (op == "W") begin
      spi_frame({1'b1, addr[ADDR_WIDTH-1:0]}, data, FRAME_BITS, rd);
      update_model(addr, data);
      check_ports(name);
    end else if (op == "A") begin
      spi_frame({1'b1, addr[ADDR_WIDTH-1:0]}, data, ABORT_BITS, rd);
      check_ports(name);
    end else if (op == "R") begin
      spi_frame({1'b0, addr[ADDR_WIDTH-1:0]}, 16'h0000, FRAME_BITS, rd);
      check_value(name, data, rd);
      check_ports(name);
    end else if (op == "G") begin
      gpio_in = data[GPIO_WIDTH-1:0];
      wait_clocks(1);
    end else if (op == "N") begin
      nfc_passthrough(name, int'(data));
    end else begin
      other_errors++;
      $display("Unknown operation %s in the vector file, line %s was skipped", op, name);
    end
  endtask

  // --------------------------------------------------
  // Vector file reader
  // --------------------------------------------------
  task automatic load_vectors();
    int          fd;
    int          r;
    string       op;
    string       nm;
    string       line;
    logic [15:0] a;
    logic [15:0] d;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the vector file %s", VECTOR_FILE);
      return;
    end
    while (!$feof(fd)) begin
      r = $fscanf(fd, "%s", op);
      if (r == 1) begin
        if (op.getc(0) == 8'h23) begin
          // Comment, drop the rest of the line
          r = $fgets(line, fd);
        end else begin
          r = $fscanf(fd, "%h %h %s", a, d, nm);
          if (r == 3) begin
            ops.push_back(op);
            addrs.push_back(a);
            datas.push_back(d);
            names.push_back(nm);
          end else begin
            other_errors++;
            $display("Vector line starting with %s is incomplete", op);
          end
        end
      end
    end
    $fclose(fd);
    if (ops.size() == 0) begin
      other_errors++;
      $display("The vector file holds no vectors");
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    arst_n   = 1'b0;
    sck      = 1'b0;
    mosi     = 1'b0;
    ss_n     = 1'b1;
    ss1_n    = 1'b1;
    nfc_miso = 1'b0;
    gpio_in  = '0;
    lfsr_q   = LFSR_SEED;
    exp_rate = RATE_DEFAULT;
    exp_gain = GAIN_DEFAULT;
    exp_dir  = '0;
    exp_out  = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    arst_n = 1'b1;
    wait_clocks(2);
    check_ports("reset");
    check_value("reset idle miso", 16'h0001, 16'(miso));
    for (int i = 0; i < ops.size(); i++) begin
      run_vector(ops[i], addrs[i], datas[i], names[i]);
    end
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Budget of one full frame per vector plus margin
  initial begin
    int limit;
    wait (loaded);
    limit = ops.size() * FRAME_BITS * 2 * HALF_SCK + 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog timeout after %0d clocks, the run did not finish", limit);
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: test/system_vectors.txt
# op addr data name  W write, A write aborted after 20 bits, R read and compare with data
# G drive gpio_i with data, N NFC pass-through for data random bits, addr unused for G and N
R 0000 0001 version0
R 0001 000A version1
R 0002 05C3 version2
R 0003 44E8 version3
R 0004 0008 rate_default
R 0005 0003 gain_default
W 0004 0030 rate_write
W 0005 0007 gain_write
R 0004 0030 rate_readback
R 0005 0007 gain_readback
W 0002 FFFF version_write
R 0002 05C3 version_kept
W 4000 A5F0 gpio_dir_write
W 4001 3C96 gpio_out_write
G 0000 5A3C gpio_in_drive
R 4002 5A3C gpio_in_read
R 2000 0000 unmapped_read
R 4001 3C96 after_unmapped
N 0000 0040 nfc_passthrough
A 0004 1234 rate_aborted
R 0004 0030 rate_after_abort

// File: tb.f
common/creator_pkg.sv
spi/spi_bus_master.sv
src/bus_decoder.sv
src/config_regs.sv
src/gpio_port.sv
src/system.sv
test/tb_system.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, fail if the log reports failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_system -f tb.f -o tb_system_sim \
  && ./obj_dir/tb_system_sim 2>&1 | tee sim.log \
  || exit 1
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
